//--- logic/ctrl_pkg.sv
/* shared opcodes, command and response structs, and watchdog constants for the
   control link. modules reference these by scoped name. */
package ctrl_pkg;

    // decoded operation, independent of the wire byte value.
    typedef enum logic [2:0] {
        OP_NOP,
        OP_WRITE,
        OP_READ,
        OP_KICK,
        OP_BAD
    } cmd_opcode_t;

    // first byte of each command on the wire.
    localparam logic [7:0] OPC_NOP   = 8'h00;
    localparam logic [7:0] OPC_WRITE = 8'h10;
    localparam logic [7:0] OPC_READ  = 8'h20;
    localparam logic [7:0] OPC_KICK  = 8'h30;

    // data holds the write value in its low byte, or the kick signature.
    typedef struct packed {
        cmd_opcode_t op;
        logic [7:0]  addr;
        logic [31:0] data;
    } cmd_t;

    typedef struct packed {
        logic [7:0] code;
        logic       err;
    } exec_rsp_t;

    localparam logic [7:0] RSP_ACK      = 8'h00;
    localparam logic [7:0] RSP_KICK_OK  = 8'h01;
    localparam logic [7:0] RSP_KICK_BAD = 8'hEE;
    localparam logic [7:0] RSP_ERR      = 8'hFF;

    localparam int REG_COUNT  = 8;
    localparam int REG_ADDR_W = $clog2(REG_COUNT);

    localparam logic [31:0] WDT_SIGNATURE = 32'hA5C3_5A3C;
    localparam logic [15:0] WDT_TICKS     = 16'd200;

    localparam int SIG_BYTES = 4;

    // wide enough to hold SIG_BYTES down to zero.
    typedef logic [$clog2(SIG_BYTES + 1)-1:0] sig_count_t;

endpackage

//--- logic/cmd_decoder.sv
/* frames the host byte stream into commands. one cmd_valid strobe follows the
   cycle that carried the last byte of each command. */
module cmd_decoder (
    input  logic              clk,
    input  logic              reset,
    input  logic [7:0]        rx_data,
    input  logic              rx_valid,
    output logic              cmd_valid,
    output ctrl_pkg::cmd_t    cmd
);

    typedef enum logic [1:0] {
        WAIT_OPCODE,
        WAIT_ADDR,
        WAIT_DATA,
        WAIT_SIG
    } dec_state_t;

    dec_state_t            state;
    dec_state_t            next_state;
    ctrl_pkg::sig_count_t  sig_count;
    ctrl_pkg::cmd_opcode_t opcode;
    ctrl_pkg::cmd_t        work;
    ctrl_pkg::cmd_t        build;
    logic                  done;

    // map the wire byte to an operation.
    always_comb begin
        case (rx_data)
            ctrl_pkg::OPC_NOP:   opcode = ctrl_pkg::OP_NOP;
            ctrl_pkg::OPC_WRITE: opcode = ctrl_pkg::OP_WRITE;
            ctrl_pkg::OPC_READ:  opcode = ctrl_pkg::OP_READ;
            ctrl_pkg::OPC_KICK:  opcode = ctrl_pkg::OP_KICK;
            default:             opcode = ctrl_pkg::OP_BAD;
        endcase
    end

    // merge the current byte into the command being built.
    always_comb begin
        next_state = state;
        build      = work;
        done       = 1'b0;
        case (state)
            WAIT_OPCODE: begin
                build.op   = opcode;
                build.addr = 8'h00;
                build.data = 32'h0;
                case (opcode)
                    ctrl_pkg::OP_WRITE,
                    ctrl_pkg::OP_READ: next_state = WAIT_ADDR;
                    ctrl_pkg::OP_KICK: next_state = WAIT_SIG;
                    default:           done = 1'b1;
                endcase
            end
            WAIT_ADDR: begin
                build.addr = rx_data;
                if (work.op == ctrl_pkg::OP_READ) begin
                    done = 1'b1;
                end else begin
                    next_state = WAIT_DATA;
                end
            end
            WAIT_DATA: begin
                build.data = {24'h0, rx_data};
                done       = 1'b1;
            end
            WAIT_SIG: begin
                // first signature byte ends up most significant.
                build.data = {work.data[23:0], rx_data};
                done       = (sig_count == ctrl_pkg::sig_count_t'(1));
            end
            default: next_state = WAIT_OPCODE;
        endcase
        if (done) begin
            next_state = WAIT_OPCODE;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= WAIT_OPCODE;
            sig_count <= '0;
            cmd_valid <= 1'b0;
        end else begin
            cmd_valid <= rx_valid && done;
            if (rx_valid) begin
                state <= next_state;
                if (state == WAIT_OPCODE) begin
                    sig_count <= ctrl_pkg::sig_count_t'(ctrl_pkg::SIG_BYTES);
                end else if (state == WAIT_SIG) begin
                    sig_count <= sig_count - ctrl_pkg::sig_count_t'(1);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rx_valid) begin
            work <= build;
            if (done) begin
                cmd <= build;
            end
        end
    end

    // a finished command leaves the decoder idle after the last byte its op frames.
    a_valid_at_idle: assert property (@(posedge clk) disable iff (reset)
        cmd_valid |-> (state == WAIT_OPCODE) && $past(rx_valid) && (
            (cmd.op == ctrl_pkg::OP_WRITE) ? ($past(state) == WAIT_DATA) :
            (cmd.op == ctrl_pkg::OP_READ)  ? ($past(state) == WAIT_ADDR) :
            (cmd.op == ctrl_pkg::OP_KICK)  ? ($past(state) == WAIT_SIG)  :
                                             ($past(state) == WAIT_OPCODE)));

endmodule

//--- logic/cmd_watchdog.sv
/* countdown watchdog. a kick with the expected signature reloads the count;
   running out pulses sys_reset for one cycle. */
module cmd_watchdog (
    input  logic                clk,
    input  logic                reset,
    input  logic                cmd_valid,
    input  ctrl_pkg::cmd_t      cmd,
    output logic                wdt_rsp_valid,
    output ctrl_pkg::exec_rsp_t wdt_rsp,
    output logic                sys_reset
);

    logic [15:0] count;
    logic        kick;
    logic        sig_ok;
    logic        expired;

    assign kick    = cmd_valid && (cmd.op == ctrl_pkg::OP_KICK);
    assign sig_ok  = (cmd.data == ctrl_pkg::WDT_SIGNATURE);
    assign expired = (count == 16'd0);

    always_ff @(posedge clk) begin
        if (reset) begin
            count         <= ctrl_pkg::WDT_TICKS;
            sys_reset     <= 1'b0;
            wdt_rsp_valid <= 1'b0;
        end else begin
            sys_reset     <= expired;
            wdt_rsp_valid <= kick;
            // a bad kick leaves the countdown running.
            if (expired || (kick && sig_ok)) begin
                count <= ctrl_pkg::WDT_TICKS;
            end else begin
                count <= count - 16'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (kick) begin
            if (sig_ok) begin
                wdt_rsp.code <= ctrl_pkg::RSP_KICK_OK;
                wdt_rsp.err  <= 1'b0;
            end else begin
                wdt_rsp.code <= ctrl_pkg::RSP_KICK_BAD;
                wdt_rsp.err  <= 1'b1;
            end
        end
    end

    // expiry reloads the count, so the pulse cannot repeat.
    a_single_pulse: assert property (@(posedge clk) disable iff (reset)
        sys_reset |=> !sys_reset);

endmodule

//--- logic/reg_bank.sv
/* eight 8-bit registers written and read by decoded commands. addresses past
   the bank answer with an error and change nothing. */
module reg_bank (
    input  logic                clk,
    input  logic                reset,
    input  logic                cmd_valid,
    input  ctrl_pkg::cmd_t      cmd,
    output logic                reg_rsp_valid,
    output ctrl_pkg::exec_rsp_t reg_rsp
);

    logic [7:0] regs [ctrl_pkg::REG_COUNT];
    logic       is_wr;
    logic       is_rd;
    logic       addr_ok;
    logic [ctrl_pkg::REG_ADDR_W-1:0] idx;

    assign is_wr   = cmd_valid && (cmd.op == ctrl_pkg::OP_WRITE);
    assign is_rd   = cmd_valid && (cmd.op == ctrl_pkg::OP_READ);
    assign addr_ok = (cmd.addr < 8'(ctrl_pkg::REG_COUNT));
    assign idx     = cmd.addr[ctrl_pkg::REG_ADDR_W-1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            reg_rsp_valid <= 1'b0;
            for (int i = 0; i < ctrl_pkg::REG_COUNT; i++) begin
                regs[i] <= 8'h00;
            end
        end else begin
            reg_rsp_valid <= is_wr || is_rd;
            if (is_wr && addr_ok) begin
                regs[idx] <= cmd.data[7:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (is_wr || is_rd) begin
            if (!addr_ok) begin
                reg_rsp.code <= ctrl_pkg::RSP_ERR;
                reg_rsp.err  <= 1'b1;
            end else if (is_wr) begin
                reg_rsp.code <= ctrl_pkg::RSP_ACK;
                reg_rsp.err  <= 1'b0;
            end else begin
                reg_rsp.code <= regs[idx];
                reg_rsp.err  <= 1'b0;
            end
        end
    end

endmodule

//--- logic/cmd_responder.sv
/* merges execute results and its own NOP and BAD answers into one registered
   response byte per command, and counts error responses. */
module cmd_responder (
    input  logic                clk,
    input  logic                reset,
    input  logic                cmd_valid,
    input  ctrl_pkg::cmd_t      cmd,
    input  logic                wdt_rsp_valid,
    input  ctrl_pkg::exec_rsp_t wdt_rsp,
    input  logic                reg_rsp_valid,
    input  ctrl_pkg::exec_rsp_t reg_rsp,
    output logic                rsp_valid,
    output logic [7:0]          rsp_data,
    output logic [7:0]          err_count
);

    logic                own_cmd;
    logic                own_valid;
    ctrl_pkg::exec_rsp_t own_rsp;
    logic                any_valid;
    ctrl_pkg::exec_rsp_t sel;

    assign own_cmd = cmd_valid &&
                     ((cmd.op == ctrl_pkg::OP_NOP) || (cmd.op == ctrl_pkg::OP_BAD));

    // one stage here lines up with the execute units.
    always_ff @(posedge clk) begin
        if (reset) begin
            own_valid <= 1'b0;
        end else begin
            own_valid <= own_cmd;
        end
    end

    always_ff @(posedge clk) begin
        if (own_cmd) begin
            own_rsp.code <= (cmd.op == ctrl_pkg::OP_NOP) ? ctrl_pkg::RSP_ACK : ctrl_pkg::RSP_ERR;
            own_rsp.err  <= (cmd.op != ctrl_pkg::OP_NOP);
        end
    end

    assign any_valid = own_valid || wdt_rsp_valid || reg_rsp_valid;

    always_comb begin
        if (own_valid) begin
            sel = own_rsp;
        end else if (wdt_rsp_valid) begin
            sel = wdt_rsp;
        end else begin
            sel = reg_rsp;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid <= 1'b0;
            err_count <= 8'h00;
        end else begin
            rsp_valid <= any_valid;
            // saturates at 255.
            if (any_valid && sel.err && (err_count != 8'hFF)) begin
                err_count <= err_count + 8'h01;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (any_valid) begin
            rsp_data <= sel.code;
        end
    end

    // the decoder issues one command per cycle, so sources never collide.
    a_one_source: assert property (@(posedge clk) disable iff (reset)
        $onehot0({own_valid, wdt_rsp_valid, reg_rsp_valid}));

endmodule

//--- logic/ctrl_link_top.sv
/* control link top level. byte stream in, one response byte out three cycles
   after the last byte of each command, plus the watchdog reset pulse. */
module ctrl_link_top (
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] rx_data,
    input  logic       rx_valid,
    output logic       rsp_valid,
    output logic [7:0] rsp_data,
    output logic [7:0] err_count,
    output logic       sys_reset
);

    logic                cmd_valid;
    ctrl_pkg::cmd_t      cmd;
    logic                wdt_rsp_valid;
    ctrl_pkg::exec_rsp_t wdt_rsp;
    logic                reg_rsp_valid;
    ctrl_pkg::exec_rsp_t reg_rsp;

    cmd_decoder u_decoder (
        .clk       (clk),
        .reset     (reset),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid),
        .cmd_valid (cmd_valid),
        .cmd       (cmd)
    );

    cmd_watchdog u_watchdog (
        .clk           (clk),
        .reset         (reset),
        .cmd_valid     (cmd_valid),
        .cmd           (cmd),
        .wdt_rsp_valid (wdt_rsp_valid),
        .wdt_rsp       (wdt_rsp),
        .sys_reset     (sys_reset)
    );

    reg_bank u_reg_bank (
        .clk           (clk),
        .reset         (reset),
        .cmd_valid     (cmd_valid),
        .cmd           (cmd),
        .reg_rsp_valid (reg_rsp_valid),
        .reg_rsp       (reg_rsp)
    );

    cmd_responder u_responder (
        .clk           (clk),
        .reset         (reset),
        .cmd_valid     (cmd_valid),
        .cmd           (cmd),
        .wdt_rsp_valid (wdt_rsp_valid),
        .wdt_rsp       (wdt_rsp),
        .reg_rsp_valid (reg_rsp_valid),
        .reg_rsp       (reg_rsp),
        .rsp_valid     (rsp_valid),
        .rsp_data      (rsp_data),
        .err_count     (err_count)
    );

endmodule

//--- verification/ctrl_link_tb.sv
/* testbench for the control link. drives framed commands and checks responses,
   err_count and sys_reset against a cycle model with concurrent assertions. */
module ctrl_link_tb;

    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        logic [31:0] due;
        logic [7:0]  data;
        logic        err;
    } exp_rsp_t;

    // cycle budget of each test, in test order.
    localparam int REG_TEST_CYCLES  = 150;
    localparam int ADDR_TEST_CYCLES = 50;
    localparam int KICK_TEST_CYCLES = 25;
    localparam int MIX_TEST_CYCLES  = 45;
    localparam int WDT_TEST_CYCLES  = 900;
    localparam int CYCLE_LIMIT = 2 * (REG_TEST_CYCLES + ADDR_TEST_CYCLES + KICK_TEST_CYCLES
        + MIX_TEST_CYCLES + WDT_TEST_CYCLES) + 4 * int'(ctrl_pkg::WDT_TICKS);

    logic       clk = 1'b0;
    logic       reset;
    logic [7:0] rx_data;
    logic       rx_valid;
    logic       rsp_valid;
    logic [7:0] rsp_data;
    logic [7:0] err_count;
    logic       sys_reset;

    int         cyc = 0;
    int         seed = 94243;
    int         fail_count = 0;
    int         test_count = 0;
    int         fails_before = 0;
    int         next_pulse = 0;
    logic [7:0] shadow [ctrl_pkg::REG_COUNT];
    exp_rsp_t   exp_q [$];
    int         reload_q [$];
    logic       exp_valid = 1'b0;
    logic [7:0] exp_data = 8'h00;
    logic       exp_sys_reset = 1'b0;
    logic [7:0] exp_err_count = 8'h00;

    ctrl_link_top uut (
        .clk       (clk),
        .reset     (reset),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid),
        .rsp_valid (rsp_valid),
        .rsp_data  (rsp_data),
        .err_count (err_count),
        .sys_reset (sys_reset)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= CYCLE_LIMIT) begin
            $display("timeout: run did not end within %0d cycles", CYCLE_LIMIT);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // model outputs for the current cycle, settled well before the next edge.
    always @(negedge clk) begin : model_step
        exp_rsp_t head;
        exp_valid     = 1'b0;
        exp_sys_reset = 1'b0;
        if (!reset) begin
            if (exp_q.size() != 0 && exp_q[0].due == cyc) begin
                head      = exp_q.pop_front();
                exp_valid = 1'b1;
                exp_data  = head.data;
                if (head.err && exp_err_count != 8'hFF) begin
                    exp_err_count = exp_err_count + 8'h01;
                end
            end
            // expiry and a good kick both restart the countdown.
            exp_sys_reset = (cyc == next_pulse);
            if (exp_sys_reset || (reload_q.size() != 0 && reload_q[0] == cyc)) begin
                next_pulse = cyc + int'(ctrl_pkg::WDT_TICKS) + 1;
            end
            if (reload_q.size() != 0 && reload_q[0] == cyc) begin
                void'(reload_q.pop_front());
            end
        end
    end

    function automatic void report_value(input string name, input logic [31:0] expected,
                                         input logic [31:0] actual);
        $display("[FAIL] %0t %s expected 0x%0h actual 0x%0h", $time, name, expected, actual);
        fail_count++;
    endfunction

    rsp_valid_timing: assert property (@(posedge clk) disable iff (reset)
        rsp_valid == exp_valid)
        else report_value("rsp_valid", 32'(exp_valid), 32'($sampled(rsp_valid)));

    rsp_data_value: assert property (@(posedge clk) disable iff (reset)
        exp_valid |-> rsp_data == exp_data)
        else report_value("rsp_data", 32'(exp_data), 32'($sampled(rsp_data)));

    sys_reset_timing: assert property (@(posedge clk) disable iff (reset)
        sys_reset == exp_sys_reset)
        else report_value("sys_reset", 32'(exp_sys_reset), 32'($sampled(sys_reset)));

    err_count_value: assert property (@(posedge clk) disable iff (reset)
        err_count == exp_err_count)
        else report_value("err_count", 32'(exp_err_count), 32'($sampled(err_count)));

    function automatic logic [7:0] rand_byte();
        return 8'($random(seed));
    endfunction

    function automatic logic [7:0] pick_bad_opcode();
        logic [7:0] b;
        b = rand_byte();
        if (b == ctrl_pkg::OPC_NOP || b == ctrl_pkg::OPC_WRITE ||
            b == ctrl_pkg::OPC_READ || b == ctrl_pkg::OPC_KICK) begin
            b = 8'h5A;
        end
        return b;
    endfunction

    // flips bits in exactly one signature byte.
    function automatic logic [31:0] corrupt_signature();
        logic [31:0] mask;
        int          pos;
        pos  = int'(rand_byte() & 8'h03);
        mask = {24'h0, rand_byte() | 8'h01} << (8 * pos);
        return ctrl_pkg::WDT_SIGNATURE ^ mask;
    endfunction

    // response due three cycles after the byte driven now.
    task automatic expect_rsp(input logic [7:0] data, input logic err);
        exp_rsp_t e;
        e.due  = 32'(cyc + 3);
        e.data = data;
        e.err  = err;
        exp_q.push_back(e);
    endtask

    task automatic drive_byte(input logic [7:0] b);
        rx_data  = b;
        rx_valid = 1'b1;
        @(posedge clk);
        #1;
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
        drive_byte(ctrl_pkg::OPC_WRITE);
        drive_byte(addr);
        if (addr < 8'(ctrl_pkg::REG_COUNT)) begin
            shadow[addr[ctrl_pkg::REG_ADDR_W-1:0]] = data;
            expect_rsp(ctrl_pkg::RSP_ACK, 1'b0);
        end else begin
            expect_rsp(ctrl_pkg::RSP_ERR, 1'b1);
        end
        drive_byte(data);
    endtask

    task automatic read_reg(input logic [7:0] addr);
        drive_byte(ctrl_pkg::OPC_READ);
        if (addr < 8'(ctrl_pkg::REG_COUNT)) begin
            expect_rsp(shadow[addr[ctrl_pkg::REG_ADDR_W-1:0]], 1'b0);
        end else begin
            expect_rsp(ctrl_pkg::RSP_ERR, 1'b1);
        end
        drive_byte(addr);
    endtask

    task automatic kick_watchdog(input logic [31:0] sig);
        drive_byte(ctrl_pkg::OPC_KICK);
        for (int i = 3; i > 0; i--) begin
            drive_byte(sig[8*i +: 8]);
        end
        if (sig == ctrl_pkg::WDT_SIGNATURE) begin
            expect_rsp(ctrl_pkg::RSP_KICK_OK, 1'b0);
            reload_q.push_back(cyc + 2);
        end else begin
            expect_rsp(ctrl_pkg::RSP_KICK_BAD, 1'b1);
        end
        drive_byte(sig[7:0]);
    endtask

    task automatic nop_cmd();
        expect_rsp(ctrl_pkg::RSP_ACK, 1'b0);
        drive_byte(ctrl_pkg::OPC_NOP);
    endtask

    task automatic bad_cmd();
        expect_rsp(ctrl_pkg::RSP_ERR, 1'b1);
        drive_byte(pick_bad_opcode());
    endtask

    task automatic idle_cycles(input int n);
        rx_valid = 1'b0;
        rx_data  = 8'h00;
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic drain_responses();
        rx_valid = 1'b0;
        rx_data  = 8'h00;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
        // the last response is checked at this edge.
        @(posedge clk);
        #1;
    endtask

    task automatic wait_sys_reset();
        rx_valid = 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (!sys_reset);
    endtask

    task automatic end_test(input string name);
        test_count++;
        $display("test %0d %s done, %0d failures", test_count, name, fail_count - fails_before);
        fails_before = fail_count;
    endtask

    initial begin : stimulus
        logic [7:0] a;
        reset    = 1'b1;
        rx_valid = 1'b0;
        rx_data  = 8'h00;
        for (int i = 0; i < ctrl_pkg::REG_COUNT; i++) begin
            shadow[i] = 8'h00;
        end
        repeat (10) @(posedge clk);
        #1;
        reset      = 1'b0;
        next_pulse = cyc + int'(ctrl_pkg::WDT_TICKS) + 1;

        for (int i = 0; i < ctrl_pkg::REG_COUNT; i++) begin
            write_reg(8'(i), rand_byte());
        end
        for (int i = 0; i < 16; i++) begin
            a = rand_byte() & 8'h07;
            write_reg(a, rand_byte());
            read_reg(a);
            read_reg(rand_byte() & 8'h07);
        end
        drain_responses();
        end_test("register write and read");

        for (int i = 0; i < 4; i++) begin
            write_reg(rand_byte() | 8'h08, rand_byte());
            read_reg(rand_byte() | 8'h08);
        end
        for (int i = 0; i < ctrl_pkg::REG_COUNT; i++) begin
            read_reg(8'(i));
        end
        drain_responses();
        end_test("address out of range");

        kick_watchdog(ctrl_pkg::WDT_SIGNATURE);
        kick_watchdog(corrupt_signature());
        kick_watchdog(ctrl_pkg::WDT_SIGNATURE);
        drain_responses();
        end_test("kick signature");

        for (int i = 0; i < 2; i++) begin
            a = rand_byte() & 8'h07;
            nop_cmd();
            bad_cmd();
            write_reg(a, rand_byte());
            read_reg(a);
            nop_cmd();
            kick_watchdog(ctrl_pkg::WDT_SIGNATURE);
            bad_cmd();
            read_reg(rand_byte() & 8'h07);
        end
        drain_responses();
        end_test("back to back mix");

        for (int i = 0; i < 3; i++) begin
            kick_watchdog(ctrl_pkg::WDT_SIGNATURE);
            idle_cycles(150);
        end
        wait_sys_reset();
        // bad kicks only, the countdown keeps running.
        kick_watchdog(corrupt_signature());
        idle_cycles(80);
        kick_watchdog(corrupt_signature());
        wait_sys_reset();
        drain_responses();
        end_test("watchdog expiry");

        $display("tests %0d, failures %0d", test_count, fail_count);
        if (fail_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- ctrl_link.f
logic/ctrl_pkg.sv
logic/cmd_decoder.sv
logic/cmd_watchdog.sv
logic/reg_bank.sv
logic/cmd_responder.sv
logic/ctrl_link_top.sv
verification/ctrl_link_tb.sv

//--- Makefile
# Verilator build and run of the control link testbench.

SIM := obj_dir/ctrl_link_tb

.PHONY: help test clean

help:
	@echo "make help   list these targets"
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module ctrl_link_tb -f ctrl_link.f -o ctrl_link_tb
	@out="$$(./$(SIM))"; \
		echo "$$out"; \
		echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf obj_dir
